//--- source/jag_pkg.sv
`default_nettype none

package jag_pkg;

	// ==============================
	// DDR port geometry
	// ==============================
	localparam int DDR_ADDR_W = 29;   // 64-bit word address
	localparam int DDR_DATA_W = 64;
	localparam int DDR_BE_W   = 8;    // One enable per byte

	// Console byte address bus
	localparam int ABUS_W = 24;

	// Upper word-address bits of the console region in DDR
	localparam logic [7:0] DDR_REGION = 8'h30;

	// ==============================
	// Host download
	// ==============================
	localparam logic [31:0] CART_BASE      = 32'h0080_0000; // Cart byte address
	localparam logic [5:0]  ROM_INDEX      = 6'd1;
	localparam logic [5:0]  BIOS_INDEX     = 6'd0;
	localparam logic [5:0]  BIOS_ALT_INDEX = 6'd2;          // Second menu entry for the BIOS

	// ==============================
	// BIOS ROM and checksum patch
	// ==============================
	localparam int BIOS_ADDR_W = 17;  // 128 KiB of bytes

	// BEQ at the cart checksum test, turned into BRA
	localparam logic [BIOS_ADDR_W-1:0] PATCH_ADDR   = 17'h0136E;
	localparam logic [7:0]             PATCH_OPCODE = 8'h60;

	// One DDR word, two views
	// Loader writes 16-bit lanes, fetch reads 32-bit halves
	// Lane 3 and half 1 sit in the top bits
	typedef union packed {
		logic [DDR_DATA_W/16-1:0][15:0] lane;
		logic [DDR_DATA_W/32-1:0][31:0] half;
	} ddr_word_t;

endpackage

`default_nettype wire

//--- source/ddr_if.sv
`timescale 1ns/1ps
`default_nettype none

// One requester's view of the DDR port
interface ddr_if import jag_pkg::*; ();

	logic [DDR_ADDR_W-1:0] addr;       // Word address
	logic                  rd;         // Held until accepted
	logic                  we;         // Held until accepted
	ddr_word_t             din;
	logic [DDR_BE_W-1:0]   be;
	logic                  busy;       // Request not taken this edge
	ddr_word_t             dout;
	logic                  dout_ready; // Single-cycle read return

	// Loader or fetch side
	modport requester (
		output addr, rd, we, din, be,
		input  busy, dout, dout_ready
	);

	// Arbiter side
	modport arbiter (
		input  addr, rd, we, din, be,
		output busy, dout, dout_ready
	);

endinterface

`default_nettype wire

//--- source/cart_loader.sv
`timescale 1ns/1ps
`default_nettype none

module cart_loader import jag_pkg::*; (
	input  wire logic       clk_sys,
	input  wire logic       reset,
	input  wire logic       ioctl_download,
	input  wire logic       ioctl_wr,
	input  wire logic [7:0] ioctl_index,
	input  wire logic [15:0] ioctl_data,
	output logic            ioctl_wait,
	output logic            load_active,
	ddr_if.requester        ddr
);

	logic              old_download;
	logic [ABUS_W-1:0] loader_addr;   // Byte address of the next word
	logic              loader_we;     // Pending DDR write
	logic [15:0]       wr_data;       // Word captured from the host
	logic [15:0]       data_bs;
	logic              accept;
	ddr_word_t         wr_word;

	wire rom_index = (ioctl_index[5:0] == ROM_INDEX);
	wire dl_start  = ~old_download & ioctl_download & rom_index;
	wire dl_end    = old_download & ~ioctl_download;

	assign accept = loader_we & ~ddr.busy;  // Taken this edge

	// ==============================
	// Download tracking and write request
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			load_active  <= 1'b0;
			loader_we    <= 1'b0;
			ioctl_wait   <= 1'b0;
			loader_addr  <= CART_BASE[ABUS_W-1:0];
		end else begin
			old_download <= ioctl_download;

			if (dl_start) begin
				loader_addr <= CART_BASE[ABUS_W-1:0]; // Cart lives at 8 MiB
				load_active <= 1'b1;
			end

			if (accept) begin
				loader_we   <= 1'b0;
				ioctl_wait  <= 1'b0;                  // Host may send the next word
				loader_addr <= loader_addr + 2'd2;    // One 16-bit word per write
			end

			if (ioctl_download && ioctl_wr && rom_index) begin
				loader_we  <= 1'b1;
				ioctl_wait <= 1'b1;   // Stall host until DDR takes it
			end

			if (dl_end) begin
				load_active <= 1'b0;
				ioctl_wait  <= 1'b0;
				loader_we   <= 1'b0;  // Nothing left to commit
			end
		end
	end

	// Host data only changes on ioctl_wr
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr && rom_index)
			wr_data <= ioctl_data;
	end

	// Host sends little endian words, console wants big endian
	assign data_bs      = {wr_data[7:0], wr_data[15:8]};
	assign wr_word.lane = {4{data_bs}};   // Same word in every lane, be picks one

	always_comb begin
		case (loader_addr[2:1])
			2'd0:    ddr.be = 8'b1100_0000;   // Offset 0 -> lane 3
			2'd1:    ddr.be = 8'b0011_0000;
			2'd2:    ddr.be = 8'b0000_1100;
			default: ddr.be = 8'b0000_0011;   // Offset 6 -> lane 0
		endcase
	end

	assign ddr.addr = {DDR_REGION, loader_addr[23:3]};
	assign ddr.din  = wr_word;
	assign ddr.we   = loader_we;
	assign ddr.rd   = 1'b0;         // Write-only requester

endmodule

`default_nettype wire

//--- source/cart_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module cart_fetch import jag_pkg::*; (
	input  wire logic              clk_sys,
	input  wire logic              reset,
	input  wire logic [ABUS_W-1:0] abus,
	input  wire logic              cart_ce_n,
	output logic                   xwaitl,
	output logic [31:0]            cart_q,
	ddr_if.requester               ddr
);

	logic                  old_ce_n;
	logic [ABUS_W-1:0]     old_abus;
	logic                  rd_req;      // Pending DDR read
	logic [DDR_ADDR_W-1:0] rd_addr;
	logic                  half_sel;    // abus[2] at the start
	logic                  wait_latch;  // Low while data is outstanding
	logic [31:0]           cart_q_r;    // Last returned half
	logic [31:0]           ret_half;
	logic                  rd_start;

	// New cycle on CE fall, or a new address while CE stays low
	assign rd_start = ~cart_ce_n & (old_ce_n | (abus != old_abus));

	// ==============================
	// Read request and wait
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_ce_n   <= 1'b1;
			old_abus   <= '0;
			rd_req     <= 1'b0;
			wait_latch <= 1'b1;   // Console runs free out of reset
		end else begin
			old_ce_n <= cart_ce_n;
			old_abus <= abus;

			if (rd_req && !ddr.busy)
				rd_req <= 1'b0;   // Accepted

			if (rd_start) begin
				rd_req     <= 1'b1;
				wait_latch <= 1'b0;   // Hold the core
			end else if (ddr.dout_ready) begin
				wait_latch <= 1'b1;
			end
		end
	end

	// Address and half chosen at the start, stable until accepted
	always_ff @(posedge clk_sys) begin
		if (rd_start) begin
			rd_addr  <= {DDR_REGION, abus[23:3]};
			half_sel <= abus[2];
		end
		if (ddr.dout_ready)
			cart_q_r <= ret_half;
	end

	// Even long word is the upper half
	assign ret_half = half_sel ? ddr.dout.half[0] : ddr.dout.half[1];

	// Data and release show up together in the return cycle
	assign cart_q = ddr.dout_ready ? ret_half : cart_q_r;
	assign xwaitl = ddr.dout_ready | wait_latch;

	assign ddr.addr = rd_addr;
	assign ddr.rd   = rd_req;
	assign ddr.we   = 1'b0;
	assign ddr.din  = '0;
	assign ddr.be   = '1;   // DDR side wants all enables on reads

endmodule

`default_nettype wire

//--- source/ddr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_arbiter import jag_pkg::*; (
	input  wire logic                  load_active,
	input  wire logic                  ddr_busy,
	input  wire logic [DDR_DATA_W-1:0] ddr_dout,
	input  wire logic                  ddr_dout_ready,
	output logic [DDR_ADDR_W-1:0]      ddr_addr,
	output logic                       ddr_rd,
	output logic                       ddr_we,
	output logic [DDR_DATA_W-1:0]      ddr_din,
	output logic [DDR_BE_W-1:0]        ddr_be,
	ddr_if.arbiter                     loader,
	ddr_if.arbiter                     fetch
);

	// ==============================
	// Request mux
	// ==============================
	// Loader owns the port for the whole download
	always_comb begin
		if (load_active) begin
			ddr_addr = loader.addr;
			ddr_rd   = loader.rd;
			ddr_we   = loader.we;
			ddr_din  = loader.din;
			ddr_be   = loader.be;
		end else begin
			ddr_addr = fetch.addr;
			ddr_rd   = fetch.rd;
			ddr_we   = fetch.we;
			ddr_din  = fetch.din;
			ddr_be   = fetch.be;
		end
	end

	// ==============================
	// Busy steering
	// ==============================
	// Non-owner always sees busy, so it just waits
	assign loader.busy = load_active ? ddr_busy : 1'b1;
	assign fetch.busy  = load_active ? 1'b1 : ddr_busy;

	// Only fetch ever reads
	assign fetch.dout        = ddr_dout;
	assign fetch.dout_ready  = ddr_dout_ready;
	assign loader.dout       = '0;
	assign loader.dout_ready = 1'b0;

endmodule

`default_nettype wire

//--- source/bios_rom.sv
`timescale 1ns/1ps
`default_nettype none

module bios_rom import jag_pkg::*; (
	input  wire logic              clk_sys,
	input  wire logic              ioctl_download,
	input  wire logic              ioctl_wr,
	input  wire logic [7:0]        ioctl_index,
	input  wire logic [24:0]       ioctl_addr,
	input  wire logic [15:0]       ioctl_data,
	input  wire logic [ABUS_W-1:0] abus,
	input  wire logic              patch_en,
	output logic [7:0]             os_rom_q
);

	logic [7:0]             mem [0:2**BIOS_ADDR_W-1];
	logic                   wr_lo = 1'b0;   // Low byte write this cycle
	logic                   wr_hi = 1'b0;   // High byte write this cycle
	logic [BIOS_ADDR_W-2:0] wr_word_addr;   // Host word address
	logic [15:0]            wr_data;
	logic [BIOS_ADDR_W-1:0] ram_addr;
	logic [7:0]             ram_din;
	logic                   ram_we;
	logic [7:0]             ram_q;
	logic [BIOS_ADDR_W-1:0] rd_addr_q;      // Address behind ram_q

	wire bios_index = (ioctl_index[5:0] == BIOS_INDEX) ||
	                  (ioctl_index[5:0] == BIOS_ALT_INDEX);
	wire os_download = ioctl_download & bios_index;

	// ==============================
	// Byte write sequencer
	// ==============================
	// One host word -> low byte, then high byte
	always_ff @(posedge clk_sys) begin
		wr_lo <= os_download & ioctl_wr;
		wr_hi <= wr_lo;
		if (os_download && ioctl_wr) begin
			wr_word_addr <= ioctl_addr[BIOS_ADDR_W-1:1];
			wr_data      <= ioctl_data;
		end
	end

	assign ram_we  = wr_lo | wr_hi;
	assign ram_din = wr_hi ? wr_data[15:8] : wr_data[7:0];

	// Host side owns the address while loading or finishing a word
	assign ram_addr = (os_download || ram_we) ? {wr_word_addr, wr_hi} :
	                                            abus[BIOS_ADDR_W-1:0];

	// ==============================
	// RAM, registered read
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (ram_we)
			mem[ram_addr] <= ram_din;
		ram_q     <= mem[ram_addr];
		rd_addr_q <= abus[BIOS_ADDR_W-1:0];
	end

	// Checksum branch forced to BRA when enabled
	assign os_rom_q = (patch_en && rd_addr_q == PATCH_ADDR) ? PATCH_OPCODE : ram_q;

endmodule

`default_nettype wire

//--- source/jag_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module jag_mem_top import jag_pkg::*; (
	input  wire logic                  clk_sys,
	input  wire logic                  reset,

	// Host download port
	input  wire logic                  ioctl_download,
	input  wire logic                  ioctl_wr,
	input  wire logic [7:0]            ioctl_index,
	input  wire logic [24:0]           ioctl_addr,
	input  wire logic [15:0]           ioctl_data,
	output logic                       ioctl_wait,

	// Console side
	input  wire logic [ABUS_W-1:0]     abus,
	input  wire logic                  cart_ce_n,
	input  wire logic                  patch_en,
	output logic [31:0]                cart_q,
	output logic                       xwaitl,
	output logic [7:0]                 os_rom_q,

	// DDR port
	input  wire logic                  ddr_busy,
	input  wire logic [DDR_DATA_W-1:0] ddr_dout,
	input  wire logic                  ddr_dout_ready,
	output logic [DDR_ADDR_W-1:0]      ddr_addr,
	output logic                       ddr_rd,
	output logic                       ddr_we,
	output logic [DDR_DATA_W-1:0]      ddr_din,
	output logic [DDR_BE_W-1:0]        ddr_be
);

	logic load_active;   // Loader owns DDR

	ddr_if loader_bus ();
	ddr_if fetch_bus ();

	// ==============================
	// Cart path
	// ==============================
	cart_loader i_cart_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_data     (ioctl_data),
		.ioctl_wait     (ioctl_wait),
		.load_active    (load_active),
		.ddr            (loader_bus.requester)
	);

	cart_fetch i_cart_fetch (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.abus      (abus),
		.cart_ce_n (cart_ce_n),
		.xwaitl    (xwaitl),
		.cart_q    (cart_q),
		.ddr       (fetch_bus.requester)
	);

	ddr_arbiter i_ddr_arbiter (
		.load_active    (load_active),
		.ddr_busy       (ddr_busy),
		.ddr_dout       (ddr_dout),
		.ddr_dout_ready (ddr_dout_ready),
		.ddr_addr       (ddr_addr),
		.ddr_rd         (ddr_rd),
		.ddr_we         (ddr_we),
		.ddr_din        (ddr_din),
		.ddr_be         (ddr_be),
		.loader         (loader_bus.arbiter),
		.fetch          (fetch_bus.arbiter)
	);

	// ==============================
	// BIOS path
	// ==============================
	bios_rom i_bios_rom (
		.clk_sys        (clk_sys),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.abus           (abus),
		.patch_en       (patch_en),
		.os_rom_q       (os_rom_q)
	);

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

// 250 MHz clock, reset held for the first 3 edges
module tb_clock (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);   // Release away from the sampling edge
		reset = 1'b0;
	end

endmodule

`default_nettype wire

//--- dv/ddr_model.sv
`timescale 1ns/1ps
`default_nettype none

// Behavioral DDR port with sparse storage and fixed read latency
module ddr_model import jag_pkg::*; (
	input  wire logic                  clk_sys,
	input  wire logic                  reset,
	input  wire logic                  rand_busy,   // Random back-pressure on
	input  wire logic [DDR_ADDR_W-1:0] addr,
	input  wire logic                  rd,
	input  wire logic                  we,
	input  wire logic [DDR_DATA_W-1:0] din,
	input  wire logic [DDR_BE_W-1:0]   be,
	output logic                       busy,
	output logic [DDR_DATA_W-1:0]      dout,
	output logic                       dout_ready
);

	logic [DDR_DATA_W-1:0] mem [logic [DDR_ADDR_W-1:0]];
	logic [DDR_DATA_W-1:0] word;
	logic [DDR_ADDR_W-1:0] rd_addr;
	int                    lat;                // Edges left until read return
	int                    write_count = 0;    // Accepted writes
	integer                seed = 83705;
	integer                rnd;

	// Unwritten words read as zero
	function automatic logic [DDR_DATA_W-1:0] read_word(input logic [DDR_ADDR_W-1:0] a);
		return mem.exists(a) ? mem[a] : '0;
	endfunction

	always @(posedge clk_sys) begin
		rnd        = $random(seed);
		dout_ready <= 1'b0;
		if (reset) begin
			busy <= 1'b0;
			lat  <= 0;
		end else begin
			if (we && !busy) begin   // Only enabled bytes change
				word = read_word(addr);
				for (int i = 0; i < DDR_BE_W; i++)
					if (be[i])
						word[8*i +: 8] = din[8*i +: 8];
				mem[addr]   = word;
				write_count = write_count + 1;
			end
			if (rd && !busy) begin
				rd_addr <= addr;
				lat     <= 3;
			end else if (lat > 0) begin
				lat <= lat - 1;
				if (lat == 1) begin    // Single-cycle return
					dout       <= read_word(rd_addr);
					dout_ready <= 1'b1;
				end
			end
			busy <= rand_busy & rnd[0];
		end
	end

endmodule

`default_nettype wire

//--- dv/tb_jag_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_jag_mem import jag_pkg::*; ();

	logic                  clk_sys, reset, rand_busy;
	logic                  ioctl_download, ioctl_wr, ioctl_wait;
	logic [7:0]            ioctl_index, os_rom_q;
	logic [24:0]           ioctl_addr;
	logic [15:0]           ioctl_data;
	logic [ABUS_W-1:0]     abus;
	logic                  cart_ce_n, patch_en, xwaitl;
	logic [31:0]           cart_q;
	logic                  ddr_busy, ddr_dout_ready, ddr_rd, ddr_we;
	logic [DDR_DATA_W-1:0] ddr_dout, ddr_din;
	logic [DDR_ADDR_W-1:0] ddr_addr;
	logic [DDR_BE_W-1:0]   ddr_be;
	logic [15:0]           cart_data [0:7];   // Last cart image sent
	logic [15:0]           bios_data [0:4];
	logic [15:0]           bios_waddr [0:4];  // Host word addresses
	int                    n;

	tb_clock i_tb_clock (.clk_sys(clk_sys), .reset(reset));

	ddr_model i_ddr_model (
		.clk_sys(clk_sys), .reset(reset), .rand_busy(rand_busy),
		.addr(ddr_addr), .rd(ddr_rd), .we(ddr_we), .din(ddr_din), .be(ddr_be),
		.busy(ddr_busy), .dout(ddr_dout), .dout_ready(ddr_dout_ready)
	);

	jag_mem_top i_jag_mem_top (.*);

	function automatic logic [15:0] swap_bytes(input logic [15:0] d);
		return {d[7:0], d[15:8]};
	endfunction

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp)
		else report_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	// ==============================
	// Cart load and fetch
	// ==============================
	task automatic load_cart(input logic [3:0] salt);
		int start_count;
		int t;
		start_count    = i_ddr_model.write_count;
		ioctl_index    = {2'b00, ROM_INDEX};
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		for (int i = 0; i < 8; i++) begin
			cart_data[i] = {salt, 4'(i), 8'(8'hA5 ^ (i * 29))};
			ioctl_addr   = 25'(2 * i);
			ioctl_data   = cart_data[i];
			ioctl_wr     = 1'b1;
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			assert (ioctl_wait) else report_error("ioctl_wait did not rise after a cart write");
			t = 0;
			while (ioctl_wait) begin   // Falls once DDR takes the word
				@(negedge clk_sys);
				t++;
				if (t > 100) report_error("Timeout: ioctl_wait stuck high during cart load");
			end
		end
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		check_value("write_count", 64'(i_ddr_model.write_count - start_count), 64'd8);
	endtask

	// Offset 0 of each 8-byte group lands in the top lane
	task automatic check_cart_image();
		logic [DDR_ADDR_W-1:0] wa;
		logic [63:0]           exp;
		for (int k = 0; k < 2; k++) begin
			wa  = {DDR_REGION, 21'(CART_BASE[23:3] + 21'(k))};
			exp = {swap_bytes(cart_data[4*k]), swap_bytes(cart_data[4*k+1]),
			       swap_bytes(cart_data[4*k+2]), swap_bytes(cart_data[4*k+3])};
			check_value($sformatf("ddr_model.mem[%h]", wa), i_ddr_model.read_word(wa), exp);
		end
	endtask

	task automatic cart_read(input logic [ABUS_W-1:0] a, input logic [31:0] exp);
		int t;
		abus      = a;
		cart_ce_n = 1'b0;
		@(negedge clk_sys);
		assert (!xwaitl) else report_error("xwaitl not low after a cart read start");
		t = 0;
		while (!xwaitl) begin
			@(negedge clk_sys);
			t++;
			if (t > 100) report_error("Timeout: xwaitl stayed low on a cart read");
		end
		check_value("cart_q", 64'(cart_q), 64'(exp));
		@(negedge clk_sys);                               // Held after release
		check_value("xwaitl", 64'(xwaitl), 64'd1);
		check_value("cart_q", 64'(cart_q), 64'(exp));
	endtask

	task automatic cart_pass(input logic [3:0] salt);
		load_cart(salt);
		check_cart_image();
		for (int j = 0; j < 4; j++)   // Even long words are upper halves
			cart_read(CART_BASE[23:0] + 24'(4 * j),
			          {swap_bytes(cart_data[2*j]), swap_bytes(cart_data[2*j+1])});
		cart_ce_n = 1'b1;
		@(negedge clk_sys);
	endtask

	// ==============================
	// BIOS load and read
	// ==============================
	task automatic load_bios();
		ioctl_index    = {2'b00, BIOS_INDEX};
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		for (int k = 0; k < 5; k++) begin
			bios_waddr[k] = (k < 4) ? 16'(k * 3) : PATCH_ADDR[16:1];
			bios_data[k]  = 16'(16'h3C00 + k * 16'h0111);
			ioctl_addr    = {8'd0, bios_waddr[k], 1'b0};
			ioctl_data    = bios_data[k];
			ioctl_wr      = 1'b1;
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			repeat (2) @(negedge clk_sys);   // Low then high byte
		end
		ioctl_download = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic bios_read(input logic [ABUS_W-1:0] a, input logic [7:0] exp);
		abus = a;
		@(negedge clk_sys);   // One cycle of RAM latency
		check_value($sformatf("os_rom_q at %h", a), 64'(os_rom_q), 64'(exp));
	endtask

	// Low byte at even address, high byte at odd
	task automatic load_and_read_bios();
		load_bios();
		for (int k = 0; k < 5; k++) begin
			bios_read({7'd0, bios_waddr[k], 1'b0}, bios_data[k][7:0]);
			bios_read({7'd0, bios_waddr[k], 1'b1}, bios_data[k][15:8]);
		end
	endtask

	task automatic check_patch();
		patch_en = 1'b1;
		bios_read({7'd0, PATCH_ADDR}, PATCH_OPCODE);
		patch_en = 1'b0;   // Loaded byte shows again
		bios_read({7'd0, PATCH_ADDR}, bios_data[4][7:0]);
	endtask

	initial begin
		rand_busy      = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		abus           = '0;
		cart_ce_n      = 1'b1;
		patch_en       = 1'b0;
		n              = 0;
		@(negedge clk_sys);   // Reset is high by now
		while (reset) begin
			@(negedge clk_sys);
			n++;
			if (n > 20) report_error("Timeout: reset never released");
		end
		cart_pass(4'h1);           // Tests 1 to 3
		load_and_read_bios();      // Test 4
		check_patch();             // Test 5
		rand_busy = 1'b1;          // Test 6 under back-pressure
		cart_pass(4'h2);
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
source/jag_pkg.sv
source/ddr_if.sv
source/cart_loader.sv
source/cart_fetch.sv
source/ddr_arbiter.sv
source/bios_rom.sv
source/jag_mem_top.sv
dv/tb_clock.sv
dv/ddr_model.sv
dv/tb_jag_mem.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_jag_mem -f filelist.f -o sim_tb
out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"
echo "$out" | grep -q '^Result: PASSED$'
